// File: cpu_pkg.sv
package cpu_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int word_w      = 16;
  localparam int reg_addr_w  = 4;
  localparam int imem_addr_w = 8;  // 256 words

  typedef logic [word_w-1:0] word_t;

  ////////////////////
  // encodings
  ////////////////////
  // 13..15 unnamed, executed as nop
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_orr  = 4'd4,
    op_eor  = 4'd5,
    op_lsl  = 4'd6,
    op_lsr  = 4'd7,
    op_asr  = 4'd8,
    op_cmp  = 4'd9,
    op_addi = 4'd10,
    op_movi = 4'd11,
    op_bcc  = 4'd12
  } opcode_t;

  // anything above ge is always
  typedef enum logic [3:0] {
    cond_eq = 4'd0,
    cond_ne = 4'd1,
    cond_cs = 4'd2,
    cond_cc = 4'd3,
    cond_mi = 4'd4,
    cond_pl = 4'd5,
    cond_lt = 4'd6,  // n != v
    cond_ge = 4'd7
  } cond_t;

  ////////////////////
  // instruction views
  ////////////////////
  typedef struct packed {
    opcode_t               opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rn;
    logic [reg_addr_w-1:0] rm;
  } instr_reg_t;

  typedef struct packed {
    opcode_t               opcode;
    logic [reg_addr_w-1:0] rd_cond;  // rd, or cond for bcc
    logic [7:0]            imm8;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t rform;  // alu, shift, cmp
    instr_imm_t iform;  // addi, movi, bcc
  } instr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

// File: cpu_if.sv
`timescale 1ns/1ps

// decode -> execute
interface issue_if;
  logic                            valid;
  cpu_pkg::opcode_t                opcode;
  logic [cpu_pkg::reg_addr_w-1:0]  rd;
  logic [cpu_pkg::reg_addr_w-1:0]  rn_idx;  // rd for addi
  logic [cpu_pkg::reg_addr_w-1:0]  rm_idx;
  cpu_pkg::word_t                  op_a;
  cpu_pkg::word_t                  op_b;
  cpu_pkg::word_t                  imm;     // imm8 zero-extended
  cpu_pkg::cond_t                  cond;
  cpu_pkg::word_t                  pc;

  modport dec_mp  (output valid, opcode, rd, rn_idx, rm_idx, op_a, op_b, imm, cond, pc);
  modport exec_mp (input  valid, opcode, rd, rn_idx, rm_idx, op_a, op_b, imm, cond, pc);
endinterface

// decode <-> register file, combinational
interface regread_if;
  logic [cpu_pkg::reg_addr_w-1:0] rd_addr1;
  logic [cpu_pkg::reg_addr_w-1:0] rd_addr2;
  cpu_pkg::word_t                 rd_data1;
  cpu_pkg::word_t                 rd_data2;

  modport dec_mp (output rd_addr1, rd_addr2, input rd_data1, rd_data2);
  modport res_mp (input rd_addr1, rd_addr2, output rd_data1, rd_data2);
endinterface

// execute -> result, registered copy comes back for forwarding
interface retire_if;
  logic                           valid;
  logic [cpu_pkg::reg_addr_w-1:0] rd;
  cpu_pkg::word_t                 data;
  logic                           we;
  logic                           fwd_valid;
  logic [cpu_pkg::reg_addr_w-1:0] fwd_rd;
  cpu_pkg::word_t                 fwd_data;
  logic                           fwd_we;

  modport exec_mp (output valid, rd, data, we, input fwd_valid, fwd_rd, fwd_data, fwd_we);
  modport res_mp  (input valid, rd, data, we, output fwd_valid, fwd_rd, fwd_data, fwd_we);
endinterface

// File: instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
  input  logic                            clk_i,
  input  logic                            reset_2_r,
  input  logic                            imem_we_i,
  input  logic [cpu_pkg::imem_addr_w-1:0] imem_addr_i,
  input  cpu_pkg::instr_t                 imem_data_i,
  input  logic                            redirect_valid_i,
  input  cpu_pkg::word_t                  redirect_pc_i,
  output logic                            fd_valid_o,
  output cpu_pkg::instr_t                 fd_instr_o,
  output cpu_pkg::word_t                  fd_pc_o,
  output cpu_pkg::word_t                  pc_o
);

  cpu_pkg::instr_t imem [2**cpu_pkg::imem_addr_w];
  cpu_pkg::word_t  pc_r;

  // loaded by the testbench while the core sits in reset
  always_ff @(posedge clk_i) begin
    if (imem_we_i) imem[imem_addr_i] <= imem_data_i;
  end

  ////////////////////
  // pc
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_2_r) begin
      pc_r <= '0;
    end else if (redirect_valid_i) begin
      pc_r <= redirect_pc_i;  // taken bcc from execute
    end else begin
      pc_r <= pc_r + cpu_pkg::word_t'(1);
    end
  end

  // fetch register, async read at pc
  always_ff @(posedge clk_i) begin
    if (reset_2_r || redirect_valid_i) begin
      fd_valid_o <= 1'b0;  // wrong-path word dropped
    end else begin
      fd_valid_o <= 1'b1;
    end
    fd_instr_o <= imem[pc_r[cpu_pkg::imem_addr_w-1:0]];
    fd_pc_o    <= pc_r;
  end

  assign pc_o = pc_r;

  // program load must not race a running core
  a_load_in_reset: assert property (@(posedge clk_i) imem_we_i |-> reset_2_r);

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic            clk_i,
  input  logic            reset_2_r,
  input  logic            flush_i,
  input  logic            fd_valid_i,
  input  cpu_pkg::instr_t fd_instr_i,
  input  cpu_pkg::word_t  fd_pc_i,
  regread_if.dec_mp       rr,
  issue_if.dec_mp         iss
);

  cpu_pkg::opcode_t                opc;
  logic                            imm_form;
  logic [cpu_pkg::reg_addr_w-1:0]  dst_idx;
  logic [cpu_pkg::reg_addr_w-1:0]  src_a_idx;
  logic [cpu_pkg::reg_addr_w-1:0]  src_b_idx;
  cpu_pkg::word_t                  imm_zx;
  cpu_pkg::cond_t                  br_cond;

  // opcode sits at the same bits in both views
  assign opc = fd_instr_i.rform.opcode;

  assign imm_form = (opc == cpu_pkg::op_addi) ||
                    (opc == cpu_pkg::op_movi) ||
                    (opc == cpu_pkg::op_bcc);

  ////////////////////
  // field selection
  ////////////////////
  // rd and rd_cond share bits 11:8
  assign dst_idx = fd_instr_i.rform.rd;

  always_comb begin
    if (imm_form) begin
      src_a_idx = fd_instr_i.iform.rd_cond;  // addi reads its own rd
    end else begin
      src_a_idx = fd_instr_i.rform.rn;
    end
  end

  // op_b goes unused in the immediate view
  assign src_b_idx = fd_instr_i.rform.rm;
  assign imm_zx    = cpu_pkg::word_t'(fd_instr_i.iform.imm8);
  assign br_cond   = cpu_pkg::cond_t'(fd_instr_i.iform.rd_cond);

  // write-through covers the retiring instr
  assign rr.rd_addr1 = src_a_idx;
  assign rr.rd_addr2 = src_b_idx;

  ////////////////////
  // decode -> execute register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_2_r || flush_i) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= fd_valid_i;
    end
    iss.opcode <= opc;
    iss.rd     <= dst_idx;
    iss.rn_idx <= src_a_idx;
    iss.rm_idx <= src_b_idx;
    iss.op_a   <= rr.rd_data1;
    iss.op_b   <= rr.rd_data2;
    iss.imm    <= imm_zx;
    iss.cond   <= br_cond;
    iss.pc     <= fd_pc_i;
  end

  // an unloaded or corrupt memory word must never issue
  a_opcode_known: assert property (
    @(posedge clk_i) disable iff (reset_2_r)
    iss.valid |-> !$isunknown(iss.opcode)
  );

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic           clk_i,
  input  logic           reset_2_r,
  issue_if.exec_mp       iss,
  retire_if.exec_mp      ret,
  output logic           redirect_valid_o,
  output cpu_pkg::word_t redirect_pc_o
);

  logic            fwd_a;
  logic            fwd_b;
  cpu_pkg::word_t  a_val;
  cpu_pkg::word_t  b_val;
  cpu_pkg::word_t  add_rhs;
  cpu_pkg::word_t  sum;
  cpu_pkg::word_t  result;
  cpu_pkg::word_t  br_off;
  logic [3:0]      shamt;
  logic            is_sub;
  logic            carry;
  logic            ovf;
  logic            we;
  logic            set_nz;
  logic            set_cv;
  logic            cond_ok;
  cpu_pkg::nzcv_t  flags_r;
  cpu_pkg::nzcv_t  flags_n;

  ////////////////////
  // forwarding
  ////////////////////
  // only the previous instr can be missing from the regfile read
  assign fwd_a = ret.fwd_valid && ret.fwd_we && (ret.fwd_rd == iss.rn_idx);
  assign fwd_b = ret.fwd_valid && ret.fwd_we && (ret.fwd_rd == iss.rm_idx);
  assign a_val = fwd_a ? ret.fwd_data : iss.op_a;
  assign b_val = fwd_b ? ret.fwd_data : iss.op_b;
  assign shamt = b_val[3:0];

  // sub and cmp use a + ~b + 1 so c means no borrow
  assign is_sub  = (iss.opcode == cpu_pkg::op_sub) || (iss.opcode == cpu_pkg::op_cmp);
  assign add_rhs = (iss.opcode == cpu_pkg::op_addi) ? iss.imm :
                   (is_sub ? ~b_val : b_val);
  assign {carry, sum} = {1'b0, a_val} + {1'b0, add_rhs} + {{cpu_pkg::word_w{1'b0}}, is_sub};
  assign ovf = (a_val[cpu_pkg::word_w-1] == add_rhs[cpu_pkg::word_w-1]) &&
               (sum[cpu_pkg::word_w-1] != a_val[cpu_pkg::word_w-1]);

  ////////////////////
  // result select
  ////////////////////
  always_comb begin
    result = sum;
    we     = 1'b0;
    set_nz = 1'b0;
    set_cv = 1'b0;
    case (iss.opcode)
      cpu_pkg::op_add,
      cpu_pkg::op_sub,
      cpu_pkg::op_addi: begin
        we     = 1'b1;
        set_nz = 1'b1;
        set_cv = 1'b1;
      end
      cpu_pkg::op_cmp: begin
        set_nz = 1'b1;  // flags only
        set_cv = 1'b1;
      end
      cpu_pkg::op_and: begin
        result = a_val & b_val;
        we     = 1'b1;
        set_nz = 1'b1;
      end
      cpu_pkg::op_orr: begin
        result = a_val | b_val;
        we     = 1'b1;
        set_nz = 1'b1;
      end
      cpu_pkg::op_eor: begin
        result = a_val ^ b_val;
        we     = 1'b1;
        set_nz = 1'b1;
      end
      cpu_pkg::op_lsl: begin
        result = a_val << shamt;
        we     = 1'b1;
      end
      cpu_pkg::op_lsr: begin
        result = a_val >> shamt;
        we     = 1'b1;
      end
      cpu_pkg::op_asr: begin
        result = cpu_pkg::word_t'($signed(a_val) >>> shamt);
        we     = 1'b1;
      end
      cpu_pkg::op_movi: begin
        result = iss.imm;
        we     = 1'b1;
      end
      default: ;  // nop, bcc
    endcase
  end

  always_comb begin
    flags_n.n = set_nz ? result[cpu_pkg::word_w-1] : flags_r.n;
    flags_n.z = set_nz ? (result == '0) : flags_r.z;
    flags_n.c = set_cv ? carry : flags_r.c;
    flags_n.v = set_cv ? ovf : flags_r.v;
  end

  always_ff @(posedge clk_i) begin
    if (reset_2_r) flags_r <= '0;
    else if (iss.valid) flags_r <= flags_n;
  end

  ////////////////////
  // branch
  ////////////////////
  always_comb begin
    case (iss.cond)
      cpu_pkg::cond_eq: cond_ok = flags_r.z;
      cpu_pkg::cond_ne: cond_ok = !flags_r.z;
      cpu_pkg::cond_cs: cond_ok = flags_r.c;
      cpu_pkg::cond_cc: cond_ok = !flags_r.c;
      cpu_pkg::cond_mi: cond_ok = flags_r.n;
      cpu_pkg::cond_pl: cond_ok = !flags_r.n;
      cpu_pkg::cond_lt: cond_ok = flags_r.n != flags_r.v;
      cpu_pkg::cond_ge: cond_ok = flags_r.n == flags_r.v;
      default:          cond_ok = 1'b1;  // always
    endcase
  end

  assign br_off           = {{8{iss.imm[7]}}, iss.imm[7:0]};  // imm8 sign-extended
  assign redirect_valid_o = iss.valid && (iss.opcode == cpu_pkg::op_bcc) && cond_ok;
  assign redirect_pc_o    = iss.pc + br_off;

  // to the retire register in result
  assign ret.valid = iss.valid;
  assign ret.rd    = iss.rd;
  assign ret.data  = result;
  assign ret.we    = we;

  // flush must kill the next issue slot
  a_no_double_redirect: assert property (
    @(posedge clk_i) disable iff (reset_2_r)
    redirect_valid_o |=> !redirect_valid_o
  );

endmodule

// File: result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic                            clk_i,
  input  logic                            reset_2_r,
  retire_if.res_mp                        ret,
  regread_if.res_mp                       rr,
  output logic                            wb_valid_o,
  output logic [cpu_pkg::reg_addr_w-1:0]  wb_rd_o,
  output cpu_pkg::word_t                  wb_data_o
);

  logic                           ret_valid_r;
  logic                           ret_we_r;
  logic [cpu_pkg::reg_addr_w-1:0] ret_rd_r;
  cpu_pkg::word_t                 ret_data_r;
  cpu_pkg::word_t                 regs_r [2**cpu_pkg::reg_addr_w];
  logic                           wr_en;

  ////////////////////
  // retire register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_2_r) begin
      ret_valid_r <= 1'b0;
      ret_we_r    <= 1'b0;
    end else begin
      ret_valid_r <= ret.valid;
      ret_we_r    <= ret.we;
    end
    ret_rd_r   <= ret.rd;
    ret_data_r <= ret.data;
  end

  assign wr_en = ret_valid_r && ret_we_r;

  // register file
  always_ff @(posedge clk_i) begin
    if (reset_2_r) begin
      for (int i = 0; i < 2**cpu_pkg::reg_addr_w; i++) regs_r[i] <= '0;
    end else if (wr_en) begin
      regs_r[ret_rd_r] <= ret_data_r;
    end
  end

  // same-cycle write wins
  assign rr.rd_data1 = (wr_en && (rr.rd_addr1 == ret_rd_r)) ?
                       ret_data_r : regs_r[rr.rd_addr1];
  assign rr.rd_data2 = (wr_en && (rr.rd_addr2 == ret_rd_r)) ?
                       ret_data_r : regs_r[rr.rd_addr2];

  assign ret.fwd_valid = ret_valid_r;
  assign ret.fwd_we    = ret_we_r;
  assign ret.fwd_rd    = ret_rd_r;
  assign ret.fwd_data  = ret_data_r;

  // writeback trace
  assign wb_valid_o = wr_en;
  assign wb_rd_o    = ret_rd_r;
  assign wb_data_o  = ret_data_r;

  a_quiet_in_reset: assert property (
    @(posedge clk_i) reset_2_r && $past(reset_2_r) |-> !wb_valid_o
  );

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            imem_we_i,
  input  logic [cpu_pkg::imem_addr_w-1:0] imem_addr_i,
  input  cpu_pkg::instr_t                 imem_data_i,
  output logic                            wb_valid_o,
  output logic [cpu_pkg::reg_addr_w-1:0]  wb_rd_o,
  output cpu_pkg::word_t                  wb_data_o,
  output cpu_pkg::word_t                  pc_o
);

  logic            reset_1_r;
  logic            reset_2_r;
  logic            redirect_valid;
  cpu_pkg::word_t  redirect_pc;
  logic            fd_valid;
  cpu_pkg::instr_t fd_instr;
  cpu_pkg::word_t  fd_pc;

  // two-flop reset sync
  always_ff @(posedge clk_i) begin
    reset_1_r <= reset_i;
    reset_2_r <= reset_1_r;
  end

  issue_if   iss ();
  regread_if rr ();
  retire_if  ret ();

  ////////////////////
  // stages
  ////////////////////
  instr_fetch fetch_i (
    .clk_i, .reset_2_r, .imem_we_i, .imem_addr_i, .imem_data_i,
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .fd_valid_o       (fd_valid),
    .fd_instr_o       (fd_instr),
    .fd_pc_o          (fd_pc),
    .pc_o
  );

  decode_stage decode_i (
    .clk_i, .reset_2_r,
    .flush_i    (redirect_valid),  // kills the word behind a taken bcc
    .fd_valid_i (fd_valid),
    .fd_instr_i (fd_instr),
    .fd_pc_i    (fd_pc),
    .rr         (rr.dec_mp),
    .iss        (iss.dec_mp)
  );

  execute_stage execute_i (
    .clk_i, .reset_2_r,
    .iss              (iss.exec_mp),
    .ret              (ret.exec_mp),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc)
  );

  result_stage result_i (
    .clk_i, .reset_2_r,
    .ret (ret.res_mp),
    .rr  (rr.res_mp),
    .wb_valid_o, .wb_rd_o, .wb_data_o
  );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           wb_valid_i,
  input logic [cpu_pkg::reg_addr_w-1:0] wb_rd_i,
  input cpu_pkg::word_t                 wb_data_i
);

  logic [cpu_pkg::reg_addr_w-1:0] exp_rd_q [$];
  cpu_pkg::word_t                 exp_data_q [$];
  int                             error_cnt = 0;
  int                             seen_cnt = 0;
  int                             reset_cycles = 0;

  // filled by the reference model before the core leaves reset
  function automatic void add_expected(input logic [cpu_pkg::reg_addr_w-1:0] rd,
                                       input cpu_pkg::word_t data);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
  endfunction

  function automatic void compare_next();
    logic [cpu_pkg::reg_addr_w-1:0] want_rd;
    cpu_pkg::word_t                 want_data;
    want_rd   = exp_rd_q.pop_front();
    want_data = exp_data_q.pop_front();
    if ((wb_rd_i != want_rd) || (wb_data_i != want_data)) begin
      $display("[ERROR] %0t: writeback %0d expected r%0d = %h, got r%0d = %h",
               $time, seen_cnt, want_rd, want_data, wb_rd_i, wb_data_i);
      error_cnt++;
    end
  endfunction

  // number of expected writebacks that never showed up
  function automatic int report_missing();
    int missing;
    missing = exp_rd_q.size();
    if (missing > 0) begin
      $display("%0d expected writebacks never happened, the first one was r%0d = %h",
               missing, exp_rd_q[0], exp_data_q[0]);
    end
    return missing;
  endfunction

  ////////////////////
  // trace monitor
  ////////////////////
  // trace sampled mid-cycle where it is stable
  always @(negedge clk_i) begin
    if (reset_i) begin
      reset_cycles++;
      if (reset_cycles > 2 && wb_valid_i) begin  // synchronized reset clears the trace by then
        $display("writeback to r%0d seen while the core is held in reset, at %0t",
                 wb_rd_i, $time);
        error_cnt++;
      end
    end else if (wb_valid_i) begin
      seen_cnt++;
      if (exp_rd_q.size() == 0) begin
        $display("extra writeback to r%0d with data %h that the model never made, at %0t",
                 wb_rd_i, wb_data_i, $time);
        error_cnt++;
      end else begin
        compare_next();
      end
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int prog_len   = 64;
  localparam int prog_aw    = 6;
  localparam int loop_pc    = prog_len - 1;     // self-loop on the last word
  localparam int max_cycles = 3 * prog_len + 20;
  localparam int drain      = 8;                // pipeline depth plus a couple of loop turns

  logic                            clk_i = 1'b0;
  logic                            reset_i;
  logic                            imem_we_i;
  logic [cpu_pkg::imem_addr_w-1:0] imem_addr_i;
  cpu_pkg::instr_t                 imem_data_i;
  logic                            wb_valid_o;
  logic [cpu_pkg::reg_addr_w-1:0]  wb_rd_o;
  cpu_pkg::word_t                  wb_data_o;
  cpu_pkg::word_t                  pc_o;

  cpu_pkg::word_t prog [prog_len];
  logic [31:0]    lfsr_state;
  int             exp_cnt;
  int             cycle_cnt;
  int             missing;
  int             error_total;
  logic           loop_seen;
  logic           timed_out;

  always #10 clk_i = ~clk_i;

  cpu_top cpu_top_i (
    .clk_i, .reset_i, .imem_we_i, .imem_addr_i, .imem_data_i,
    .wb_valid_o, .wb_rd_o, .wb_data_o, .pc_o
  );

  tb_checker checker_i (
    .clk_i, .reset_i,
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o)
  );

  ////////////////////
  // program generator
  ////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois form shifting right
  endfunction

  // one lfsr step per bit
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val        = {val[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  function automatic void build_program();
    logic [7:0] opc;
    logic [7:0] f1;
    logic [7:0] f2;
    logic [7:0] f3;
    int         off;
    for (int i = 0; i < loop_pc; i++) begin
      opc = take_bits(4);
      f1  = take_bits(4);
      f2  = take_bits(4);
      f3  = take_bits(4);
      if (opc[3:0] == cpu_pkg::op_bcc) begin
        off = 1 + int'(take_bits(2));  // forward 1..4
        if (i + off > loop_pc) off = loop_pc - i;
        prog[i] = {opc[3:0], f1[3:0], 8'(off)};
      end else begin
        prog[i] = {opc[3:0], f1[3:0], f2[3:0], f3[3:0]};
      end
    end
    prog[loop_pc] = {cpu_pkg::op_bcc, 4'hf, 8'h00};  // always taken with offset 0
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  // walks the program in order and hands each register write to the checker
  function automatic int run_model();
    cpu_pkg::word_t   regs [16];
    cpu_pkg::nzcv_t   f;
    cpu_pkg::word_t   pc;
    cpu_pkg::word_t   instr;
    cpu_pkg::word_t   a;
    cpu_pkg::word_t   b;
    cpu_pkg::word_t   res;
    cpu_pkg::opcode_t opc;
    logic [3:0]       rd;
    logic [3:0]       rn;
    logic [3:0]       rm;
    logic [7:0]       imm8;
    logic [16:0]      wide;
    logic             wr;
    logic             taken;
    int               cnt;
    int               steps;
    for (int i = 0; i < 16; i++) regs[i] = '0;
    f     = '0;
    pc    = '0;
    cnt   = 0;
    steps = 0;
    while ((pc != cpu_pkg::word_t'(loop_pc)) && (steps < prog_len)) begin
      instr = prog[pc[prog_aw-1:0]];
      opc   = cpu_pkg::opcode_t'(instr[15:12]);
      rd    = instr[11:8];
      rn    = instr[7:4];
      rm    = instr[3:0];
      imm8  = instr[7:0];
      a     = regs[rn];
      b     = regs[rm];
      res   = '0;
      wr    = 1'b0;
      taken = 1'b0;
      case (opc)
        cpu_pkg::op_add, cpu_pkg::op_addi: begin
          if (opc == cpu_pkg::op_addi) begin
            a = regs[rd];
            b = {8'h00, imm8};
          end
          wide = {1'b0, a} + {1'b0, b};
          res  = wide[15:0];
          f.c  = wide[16];
          f.v  = (a[15] == b[15]) && (res[15] != a[15]);
          wr   = 1'b1;
        end
        cpu_pkg::op_sub, cpu_pkg::op_cmp: begin
          res = a - b;
          f.c = (a >= b);  // no borrow
          f.v = (a[15] != b[15]) && (res[15] != a[15]);
          wr  = (opc == cpu_pkg::op_sub);
        end
        cpu_pkg::op_and: begin
          res = a & b;
          wr  = 1'b1;
        end
        cpu_pkg::op_orr: begin
          res = a | b;
          wr  = 1'b1;
        end
        cpu_pkg::op_eor: begin
          res = a ^ b;
          wr  = 1'b1;
        end
        cpu_pkg::op_lsl: begin
          res = a << b[3:0];
          wr  = 1'b1;
        end
        cpu_pkg::op_lsr: begin
          res = a >> b[3:0];
          wr  = 1'b1;
        end
        cpu_pkg::op_asr: begin
          res = $unsigned($signed(a) >>> b[3:0]);
          wr  = 1'b1;
        end
        cpu_pkg::op_movi: begin
          res = {8'h00, imm8};
          wr  = 1'b1;
        end
        cpu_pkg::op_bcc: begin
          case (rd)  // condition field
            4'd0:    taken = f.z;
            4'd1:    taken = !f.z;
            4'd2:    taken = f.c;
            4'd3:    taken = !f.c;
            4'd4:    taken = f.n;
            4'd5:    taken = !f.n;
            4'd6:    taken = (f.n != f.v);
            4'd7:    taken = (f.n == f.v);
            default: taken = 1'b1;
          endcase
        end
        default: ;
      endcase
      if (opc inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_cmp, cpu_pkg::op_addi,
                      cpu_pkg::op_and, cpu_pkg::op_orr, cpu_pkg::op_eor}) begin
        f.n = res[15];
        f.z = (res == '0);
      end
      if (wr) begin
        regs[rd] = res;
        checker_i.add_expected(rd, res);
        cnt++;
      end
      if (taken) pc = pc + {{8{imm8[7]}}, imm8};
      else pc = pc + 16'd1;
      steps++;
    end
    return cnt;
  endfunction

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    reset_i     = 1'b1;
    imem_we_i   = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    lfsr_state  = 32'h86169a91;
    loop_seen   = 1'b0;
    timed_out   = 1'b0;
    cycle_cnt   = 0;
    build_program();
    exp_cnt = run_model();

    // the load runs once the synchronized reset is up
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk_i);
      imem_we_i   = 1'b1;
      imem_addr_i = 8'(i);
      imem_data_i = prog[i];
    end
    @(negedge clk_i);
    imem_we_i = 1'b0;
    reset_i   = 1'b0;

    // done once fetch reaches the self-loop word
    while (!loop_seen && (cycle_cnt < max_cycles)) begin
      @(negedge clk_i);
      cycle_cnt++;
      if (pc_o == cpu_pkg::word_t'(loop_pc)) loop_seen = 1'b1;
    end
    if (!loop_seen) begin
      $display("timeout: the core did not reach the self-loop within %0d cycles", max_cycles);
      timed_out = 1'b1;
    end else begin
      repeat (drain) @(negedge clk_i);
    end

    missing     = checker_i.report_missing();
    error_total = checker_i.error_cnt + missing + int'(timed_out);
    $display("writebacks expected %0d, seen %0d, missing %0d, errors %0d",
             exp_cnt, checker_i.seen_cnt, missing, error_total);
    if (error_total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: project.f
cpu_pkg.sv
cpu_if.sv
instr_fetch.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
